/* project.f */
+incdir+common
common/mem_stage_pkg.sv
common/dmem_if.sv
design/store_align.sv
design/treat_data.sv
data_mem/data_mem.sv
design/load_extend.sv
design/mem_stage.sv
tb/mem_stage_checker.sv
tb/tb_mem_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_mem_stage -o sim_mem_stage
./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

/* tb/tb_mem_stage.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module tb_mem_stage import mem_stage_pkg::*; ();

    localparam int FILL_WORDS      = DMEM_DEPTH;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_OPS      = 400;
    localparam int TIMEOUT_CYCLES  = 2 * (FILL_WORDS + DIRECTED_CYCLES + RANDOM_OPS);

    logic       clk;
    logic       rst_n;
    logic       ce;
    logic       pending_request;
    opcode_t    opcode;
    funct3_t    funct3;
    byte_addr_t mem_addr;
    data_t      store_value;
    reg_addr_t  rd_addr;
    data_t      alu_value;
    reg_addr_t  alu_rd_addr;
    data_t      alu_rd_data;
    reg_addr_t  load_rd_addr;
    data_t      load_rd_data;
    int         check_count;
    int         error_count;
    int         cycles = 0;
    int         errors_before = 0;
    funct3_t    sizes [5] = '{`F3_BYTE, `F3_HALF, `F3_WORD, `F3_BYTE_U, `F3_HALF_U};

    mem_stage DUT (.*);

    mem_stage_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic opcode_t onehot(int bit_pos);
        return opcode_t'(1) << bit_pos;
    endfunction

    task automatic drive(opcode_t op, funct3_t size, byte_addr_t addr, data_t value,
                         reg_addr_t rd, data_t alu, logic en, logic stall);
        @(negedge clk);
        opcode          = op;
        funct3          = size;
        mem_addr        = addr;
        store_value     = value;
        rd_addr         = rd;
        alu_value       = alu;
        ce              = en;
        pending_request = stall;
    endtask

    task automatic store(funct3_t size, byte_addr_t addr, data_t value);
        drive(onehot(`STORE_WORD), size, addr, value, '0, '0, 1'b1, 1'b0);
    endtask

    task automatic load(funct3_t size, byte_addr_t addr, reg_addr_t rd);
        drive(onehot(`LOAD_WORD), size, addr, '0, rd, '0, 1'b1, 1'b0);
    endtask

    // idle cycles let the last load reach the outputs
    task automatic end_test(string name);
        repeat (3) drive('0, '0, '0, '0, '0, '0, 1'b0, 1'b0);
        #1;
        $display("test %-8s %s, %0d errors", name,
                 (error_count == errors_before) ? "ok" : "failed", error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int      kind;
        opcode_t op;
        void'($urandom(80));
        rst_n           = 1'b0;
        ce              = 1'b0;
        pending_request = 1'b0;
        opcode          = '0;
        funct3          = '0;
        mem_addr        = '0;
        store_value     = '0;
        rd_addr         = '0;
        alu_value       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int w = 0; w < FILL_WORDS; w++) begin
            store(`F3_WORD, byte_addr_t'(w * 4), {8'(w), 8'(~w), 8'(w ^ 'h5a), 8'(w * 7 + 3)});
        end
        end_test("fill");

        drive(onehot(`RTYPE), '0, '0, '0, 5'd3, 32'hdead_beef, 1'b1, 1'b0);
        drive(onehot(`LUI), '0, '0, '0, 5'd4, 32'h1234_5000, 1'b0, 1'b0);
        drive('0, '0, '0, '0, 5'd6, 32'h0bad_0bad, 1'b1, 1'b0);   // idle clears
        drive(onehot(`AUIPC), '0, '0, '0, 5'd31, 32'h0000_0ffc, 1'b0, 1'b1);
        end_test("alu");

        store(`F3_WORD, 10'h040, 32'h1234_5678);
        load(`F3_WORD, 10'h040, 5'd5);
        store(`F3_WORD, 10'h044, 32'hcafe_f00d);
        load(`F3_WORD, 10'h044, 5'd6);
        load(`F3_WORD, 10'h040, 5'd7);
        end_test("word");

        for (int i = 0; i < 4; i++) begin
            store(`F3_BYTE, byte_addr_t'('h100 + i), data_t'('h70 + 32 * i));
        end
        store(`F3_HALF, 10'h104, 32'h0000_8001);
        store(`F3_HALF, 10'h109, 32'h0000_f00f);    // misaligned half
        store(`F3_HALF_U, 10'h10a, 32'h0000_7ffe);
        store(`F3_HALF, 10'h10f, 32'h0000_a55a);
        for (int a = 'h100; a < 'h110; a++) begin
            for (int s = 0; s < 5; s++) begin
                load(sizes[s], byte_addr_t'(a), reg_addr_t'(1 + (a + s) % 31));
            end
        end
        end_test("subword");

        drive(onehot(`STORE_WORD), `F3_WORD, 10'h040, 32'hffff_ffff, '0, '0, 1'b1, 1'b1);
        drive(onehot(`STORE_WORD), `F3_BYTE, 10'h041, 32'h0000_0055, '0, '0, 1'b0, 1'b0);
        drive(onehot(`LOAD_WORD), `F3_WORD, 10'h040, '0, 5'd8, '0, 1'b1, 1'b1);
        drive(onehot(`LOAD_WORD), `F3_HALF, 10'h044, '0, 5'd9, '0, 1'b0, 1'b0);
        load(`F3_WORD, 10'h040, 5'd10);
        end_test("stall");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            kind = $urandom_range(0, 9);
            if (kind < 3) begin
                op = onehot(`LOAD_WORD);
            end else if (kind < 6) begin
                op = onehot(`STORE_WORD);
            end else if (kind < 9) begin
                op = onehot($urandom_range(`RTYPE, `AUIPC));
            end else begin
                op = '0;
            end
            drive(op, sizes[$urandom_range(0, 4)], byte_addr_t'($urandom), $urandom,
                  reg_addr_t'($urandom), $urandom, $urandom_range(0, 7) != 0,
                  $urandom_range(0, 5) == 0);
        end
        end_test("random");

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb/mem_stage_checker.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module mem_stage_checker import mem_stage_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ce,
    input  logic       pending_request,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  byte_addr_t mem_addr,
    input  data_t      store_value,
    input  reg_addr_t  rd_addr,
    input  data_t      alu_value,
    input  reg_addr_t  alu_rd_addr,
    input  data_t      alu_rd_data,
    input  reg_addr_t  load_rd_addr,
    input  data_t      load_rd_data,
    output int         check_count,
    output int         error_count
);

    data_t     model_mem [DMEM_DEPTH];
    reg_addr_t exp_alu_rd = '0;
    data_t     exp_alu_data = '0;
    reg_addr_t exp_ld_rd [2] = '{default: '0};     // [1] is due at this edge
    data_t     exp_ld_data [2] = '{default: '0};
    int        checks = 0;
    int        errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    function automatic data_t store_ref(data_t old, funct3_t size, byte_off_t off, data_t value);
        data_t result;
        int    lane;
        result = old;
        lane   = int'(off);
        case (size)
            `F3_BYTE, `F3_BYTE_U: result[8*lane +: 8] = value[7:0];
            `F3_HALF, `F3_HALF_U: result[16*(lane/2) +: 16] = value[15:0];   // aligned down
            default:              result = value;
        endcase
        return result;
    endfunction

    function automatic data_t load_ref(data_t word, funct3_t size, byte_off_t off);
        logic [7:0]  b;
        logic [15:0] h;
        int          lane;
        lane = int'(off);
        b    = 8'(word >> (8 * lane));
        h    = 16'(word >> (16 * (lane / 2)));
        case (size)
            `F3_BYTE:   return 32'($signed(b));
            `F3_HALF:   return 32'($signed(h));
            `F3_BYTE_U: return 32'(b);
            `F3_HALF_U: return 32'(h);
            default:    return word;
        endcase
    endfunction

    always @(posedge clk) begin : sample
        word_addr_t widx;
        byte_off_t  off;
        logic       mem_ok;
        widx           = word_addr_t'(mem_addr >> 2);
        off            = byte_off_t'(mem_addr);
        mem_ok         = rst_n && ce && !pending_request;
        exp_ld_rd[1]   = exp_ld_rd[0];
        exp_ld_data[1] = exp_ld_data[0];
        exp_ld_rd[0]   = '0;
        exp_ld_data[0] = '0;
        exp_alu_rd     = '0;
        exp_alu_data   = '0;
        if (mem_ok && opcode[`LOAD_WORD]) begin
            exp_ld_rd[0] = rd_addr;
            if (rd_addr != '0) begin
                exp_ld_data[0] = load_ref(model_mem[widx], funct3, off);
            end
        end else if (mem_ok && opcode[`STORE_WORD]) begin
            model_mem[widx] = store_ref(model_mem[widx], funct3, off, store_value);
        end else if (rst_n && opcode[`OPCODE_WIDTH-1:`RTYPE] != '0) begin
            exp_alu_rd   = rd_addr;   // ce does not gate alu results
            exp_alu_data = alu_value;
        end
    end

    task automatic compare(string field, data_t got, data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, field, got, want);
        end
    endtask

    // outputs are stable between rising edges
    always @(negedge clk) begin
        compare("alu_rd_addr", data_t'(alu_rd_addr), data_t'(exp_alu_rd));
        compare("alu_rd_data", alu_rd_data, exp_alu_data);
        compare("load_rd_addr", data_t'(load_rd_addr), data_t'(exp_ld_rd[1]));
        compare("load_rd_data", load_rd_data, exp_ld_data[1]);
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage import mem_stage_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ce,
    input  logic       pending_request,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  byte_addr_t mem_addr,
    input  data_t      store_value,
    input  reg_addr_t  rd_addr,
    input  data_t      alu_value,
    output reg_addr_t  alu_rd_addr,
    output data_t      alu_rd_data,
    output reg_addr_t  load_rd_addr,
    output data_t      load_rd_data
);

    data_t     aligned_data;
    byte_en_t  byte_en;
    reg_addr_t ld_rd_addr;
    funct3_t   ld_funct3;
    byte_off_t ld_offset;
    data_t     rdata;

    dmem_if dmem_bus ();

    store_align u_store_align (
        .funct3       (funct3),
        .offset       (mem_addr[BYTE_OFF_WIDTH-1:0]),
        .store_value  (store_value),
        .aligned_data (aligned_data),
        .byte_en      (byte_en)
    );

    treat_data u_treat_data (
        .clk             (clk),
        .rst_n           (rst_n),
        .ce              (ce),
        .pending_request (pending_request),
        .opcode          (opcode),
        .funct3          (funct3),
        .mem_addr        (mem_addr),
        .aligned_data    (aligned_data),
        .byte_en         (byte_en),
        .rd_addr         (rd_addr),
        .alu_value       (alu_value),
        .dmem            (dmem_bus.requester),
        .ld_rd_addr      (ld_rd_addr),
        .ld_funct3       (ld_funct3),
        .ld_offset       (ld_offset),
        .alu_rd_addr     (alu_rd_addr),
        .alu_rd_data     (alu_rd_data)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .dmem  (dmem_bus.memory),
        .rdata (rdata)
    );

    load_extend u_load_extend (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_en      (dmem_bus.load_en),
        .ld_rd_addr   (ld_rd_addr),
        .ld_funct3    (ld_funct3),
        .ld_offset    (ld_offset),
        .rdata        (rdata),
        .load_rd_addr (load_rd_addr),
        .load_rd_data (load_rd_data)
    );

endmodule

/* design/load_extend.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module load_extend import mem_stage_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_en,
    input  reg_addr_t  ld_rd_addr,
    input  funct3_t    ld_funct3,
    input  byte_off_t  ld_offset,
    input  data_t      rdata,
    output reg_addr_t  load_rd_addr,
    output data_t      load_rd_data
);

    reg_addr_t rd_q;
    funct3_t   funct3_q;
    byte_off_t offset_q;
    byte_t     sel_byte;
    half_t     sel_half;
    data_t     extended;

    // tag travels alongside the memory read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q     <= '0;
            funct3_q <= '0;
            offset_q <= '0;
        end else if (load_en) begin
            rd_q     <= ld_rd_addr;
            funct3_q <= ld_funct3;
            offset_q <= ld_offset;
        end else begin
            rd_q <= '0;   // no load this cycle
        end
    end

    assign sel_byte = rdata[8*offset_q +: 8];
    assign sel_half = offset_q[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (funct3_q)
            `F3_BYTE:   extended = {{24{sel_byte[7]}}, sel_byte};
            `F3_HALF:   extended = {{16{sel_half[15]}}, sel_half};
            `F3_BYTE_U: extended = {24'd0, sel_byte};
            `F3_HALF_U: extended = {16'd0, sel_half};
            default:    extended = rdata;
        endcase
    end

    assign load_rd_addr = rd_q;
    assign load_rd_data = (rd_q == '0) ? '0 : extended;

endmodule

/* data_mem/data_mem.sv */
`timescale 1ns/1ps

module data_mem import mem_stage_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    dmem_if.memory   dmem,
    output data_t    rdata
);

    data_t mem [DMEM_DEPTH];

    // byte-lane write
    always_ff @(posedge clk) begin
        if (dmem.store_en) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                if (dmem.store_byte_en[i]) begin
                    mem[dmem.store_addr][8*i +: 8] <= dmem.store_data[8*i +: 8];
                end
            end
        end
    end

    // registered read held between loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (dmem.load_en) begin
            rdata <= mem[dmem.load_addr];
        end
    end

endmodule

/* design/treat_data.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module treat_data import mem_stage_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         ce,
    input  logic         pending_request,
    input  opcode_t      opcode,
    input  funct3_t      funct3,
    input  byte_addr_t   mem_addr,
    input  data_t        aligned_data,
    input  byte_en_t     byte_en,
    input  reg_addr_t    rd_addr,
    input  data_t        alu_value,
    dmem_if.requester    dmem,
    output reg_addr_t    ld_rd_addr,
    output funct3_t      ld_funct3,
    output byte_off_t    ld_offset,
    output reg_addr_t    alu_rd_addr,
    output data_t        alu_rd_data
);

    logic       op_load;
    logic       op_store;
    logic       op_alu;
    logic       mem_ok;
    word_addr_t word_addr;

    assign op_load  = opcode[`LOAD_WORD];
    assign op_store = opcode[`STORE_WORD];
    assign op_alu   = opcode[`RTYPE] | opcode[`ITYPE] | opcode[`JAL]
                    | opcode[`JALR] | opcode[`LUI] | opcode[`AUIPC];

    assign mem_ok    = ce && !pending_request;   // stall drops the access
    assign word_addr = mem_addr[BYTE_OFF_WIDTH +: `WORD_ADDR_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem.load_en       <= 1'b0;
            dmem.load_addr     <= '0;
            dmem.store_en      <= 1'b0;
            dmem.store_addr    <= '0;
            dmem.store_data    <= '0;
            dmem.store_byte_en <= '0;
            ld_rd_addr         <= '0;
            ld_funct3          <= '0;
            ld_offset          <= '0;
            alu_rd_addr        <= '0;
            alu_rd_data        <= '0;
        end else begin
            // strobes and writeback are single-cycle
            dmem.load_en  <= 1'b0;
            dmem.store_en <= 1'b0;
            alu_rd_addr   <= '0;
            alu_rd_data   <= '0;
            if (mem_ok && op_load) begin
                dmem.load_en   <= 1'b1;
                dmem.load_addr <= word_addr;
                ld_rd_addr     <= rd_addr;
                ld_funct3      <= funct3;
                ld_offset      <= mem_addr[BYTE_OFF_WIDTH-1:0];
            end else if (mem_ok && op_store) begin
                dmem.store_en      <= 1'b1;
                dmem.store_addr    <= word_addr;
                dmem.store_data    <= aligned_data;
                dmem.store_byte_en <= byte_en;
            end else if (op_alu) begin
                alu_rd_addr <= rd_addr;   // ce not required here
                alu_rd_data <= alu_value;
            end else begin
                dmem.load_addr     <= '0;
                dmem.store_addr    <= '0;
                dmem.store_data    <= '0;
                dmem.store_byte_en <= '0;
                ld_rd_addr         <= '0;
                ld_funct3          <= '0;
                ld_offset          <= '0;
            end
        end
    end

endmodule

/* design/store_align.sv */
`timescale 1ns/1ps

`include "mem_stage_config.svh"

module store_align import mem_stage_pkg::*; (
    input  funct3_t   funct3,
    input  byte_off_t offset,
    input  data_t     store_value,
    output data_t     aligned_data,
    output byte_en_t  byte_en
);

    byte_t low_byte;
    half_t low_half;

    assign low_byte = store_value[7:0];
    assign low_half = store_value[15:0];

    // replicate so every candidate lane carries the value
    always_comb begin
        case (funct3)
            `F3_BYTE, `F3_BYTE_U: begin
                aligned_data = {BYTES_PER_WORD{low_byte}};
            end
            `F3_HALF, `F3_HALF_U: begin
                aligned_data = {(BYTES_PER_WORD / 2){low_half}};
            end
            default: begin
                aligned_data = store_value;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            `F3_BYTE, `F3_BYTE_U: begin
                byte_en = byte_en_t'(1) << offset;
            end
            `F3_HALF, `F3_HALF_U: begin
                // misaligned half drops to the lower boundary
                if (offset[1]) begin
                    byte_en = 4'b1100;
                end else begin
                    byte_en = 4'b0011;
                end
            end
            default: begin
                byte_en = '1;   // word ignores the offset
            end
        endcase
    end

endmodule

/* common/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if import mem_stage_pkg::*; ();

    logic       load_en;
    word_addr_t load_addr;

    logic       store_en;
    word_addr_t store_addr;
    data_t      store_data;      // already on its byte lanes
    byte_en_t   store_byte_en;

    modport requester (
        output load_en,
        output load_addr,
        output store_en,
        output store_addr,
        output store_data,
        output store_byte_en
    );

    modport memory (
        input load_en,
        input load_addr,
        input store_en,
        input store_addr,
        input store_data,
        input store_byte_en
    );

endinterface

/* common/mem_stage_pkg.sv */
package mem_stage_pkg;

`include "mem_stage_config.svh"

    localparam int BYTES_PER_WORD = `DATA_WIDTH / 8;
    localparam int BYTE_OFF_WIDTH = $clog2(BYTES_PER_WORD);
    localparam int DMEM_DEPTH     = 1 << `WORD_ADDR_WIDTH;
    localparam int FUNCT3_WIDTH   = 3;

    // data path
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [15:0]            half_t;
    typedef logic [7:0]             byte_t;

    // addressing
    typedef logic [`BYTE_ADDR_WIDTH-1:0] byte_addr_t;
    typedef logic [`WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [BYTE_OFF_WIDTH-1:0]   byte_off_t;  // lane within a word
    typedef logic [BYTES_PER_WORD-1:0]   byte_en_t;

    // instruction side
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;   // x0 means no result
    typedef logic [`OPCODE_WIDTH-1:0]   opcode_t;     // one-hot
    typedef logic [FUNCT3_WIDTH-1:0]    funct3_t;

endpackage

/* common/mem_stage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

`define DATA_WIDTH      32
`define BYTE_ADDR_WIDTH 10
`define WORD_ADDR_WIDTH 8   // 256 words
`define REG_ADDR_WIDTH  5
`define OPCODE_WIDTH    8

// one-hot opcode bit positions
`define LOAD_WORD  0
`define STORE_WORD 1
`define RTYPE      2
`define ITYPE      3
`define JAL        4
`define JALR       5
`define LUI        6
`define AUIPC      7

// access size in funct3 encoding
`define F3_BYTE   3'd0
`define F3_HALF   3'd1
`define F3_WORD   3'd2
`define F3_BYTE_U 3'd4
`define F3_HALF_U 3'd5

`endif
